// File: design/apb_host_port.sv
`timescale 1ns/1ps
module apb_host_port
   import proc_pkg::*;
#(
   parameter int IMEM_DEPTH = 256,
   parameter int DMEM_DEPTH = 256
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [15:0]       paddr,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [DATA_W-1:0] pwdata,
   input  logic              halt_seen,
   input  logic              illegal_seen,
   input  logic [DATA_W-1:0] host_imem_rdata,
   input  logic [DATA_W-1:0] host_dmem_rdata,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   output logic              run,
   output logic              host_imem_we,
   output logic              host_dmem_we,
   output logic [15:0]       host_addr,
   output logic [DATA_W-1:0] host_wdata
);

   logic access;
   logic sel_imem;
   logic sel_dmem;
   logic sel_ctrl;
   logic sel_stat;
   logic mem_ok;
   logic start;
   logic halted;
   logic err;

   function automatic logic in_range(input logic [15:0] addr, input logic [15:0] base,
                                     input int depth);
      int off;
      off = int'(addr) - int'(base);
      return (off >= 0) && (off < depth);
   endfunction

   assign access   = psel & penable;
   assign sel_imem = in_range(paddr, IMEM_BASE, IMEM_DEPTH);
   assign sel_dmem = in_range(paddr, DMEM_BASE, DMEM_DEPTH);
   assign sel_ctrl = (paddr == CTRL_ADDR);
   assign sel_stat = (paddr == STAT_ADDR);

   // Host may touch the memories only while the core is idle
   assign mem_ok       = access & pwrite & ~run;
   assign host_imem_we = mem_ok & sel_imem;
   assign host_dmem_we = mem_ok & sel_dmem;
   assign host_addr    = sel_dmem ? paddr - DMEM_BASE : paddr - IMEM_BASE;
   assign host_wdata   = pwdata;

   assign pready  = 1'b1;
   assign pslverr = access & (((sel_imem | sel_dmem) & run) | (sel_stat & pwrite) |
                              ~(sel_imem | sel_dmem | sel_ctrl | sel_stat));

   always_comb begin
      prdata = '0;
      if (sel_imem && !run) begin
         prdata = host_imem_rdata;
      end else if (sel_dmem && !run) begin
         prdata = host_dmem_rdata;
      end else if (sel_ctrl) begin
         prdata[CTRL_RUN_BIT] = run;
      end else if (sel_stat) begin
         prdata[STAT_HALT_BIT] = halted;
         prdata[STAT_ERR_BIT]  = err;
      end
   end

   // Writing 0 to CTRL does nothing, a run only ends at HALT or an illegal opcode
   assign start = access & pwrite & sel_ctrl & pwdata[CTRL_RUN_BIT];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run    <= 1'b0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (start) begin
         run    <= 1'b1;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (halt_seen || illegal_seen) begin
         run    <= 1'b0;
         halted <= 1'b1;
         err    <= err | illegal_seen;
      end
   end

endmodule

// File: design/decode.sv
`timescale 1ns/1ps
module decode
   import proc_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              run,
   input  logic              fd_valid,
   input  logic [DATA_W-1:0] fd_instr,
   input  logic [DATA_W-1:0] fd_pc,
   input  logic              flush,
   input  logic              wb_en,
   input  logic [REG_AW-1:0] wb_reg,
   input  logic [DATA_W-1:0] wb_data,
   output logic              stall,
   output logic              de_valid,
   output opcode_t           de_op,
   output alu_op_t           de_alu_op,
   output logic [DATA_W-1:0] de_a,
   output logic [DATA_W-1:0] de_b,
   output logic [DATA_W-1:0] de_store_data,
   output logic [DATA_W-1:0] de_imm,
   output logic [DATA_W-1:0] de_pc,
   output logic [REG_AW-1:0] de_dst,
   output logic              de_wen,
   output logic              de_illegal
);

   logic [DATA_W-1:0] rf [NUM_REGS];
   opcode_t           op;
   funct_t            fn;
   alu_op_t           alu_op;
   logic [REG_AW-1:0] rs, rt, rd, dst;
   logic [DATA_W-1:0] rs_val, rt_val;
   logic [DATA_W-1:0] imm5, imm8, imm11, imm;
   logic              uses_rs, uses_rt, rt_to_b, wen, illegal;
   logic              hz_e, hz_m;
   // Shadow of the destination now sitting in the memory stage
   logic              m_wen;
   logic [REG_AW-1:0] m_dst;

   assign op = opcode_t'(fd_instr[OP_HI:OP_LO]);
   assign fn = funct_t'(fd_instr[FN_HI:FN_LO]);
   assign rs = fd_instr[RS_HI:RS_LO];
   assign rt = fd_instr[RT_HI:RT_LO];
   assign rd = fd_instr[RD_HI:RD_LO];

   assign imm5  = {{(DATA_W-IMM5_W){fd_instr[IMM5_W-1]}}, fd_instr[IMM5_W-1:0]};
   assign imm8  = {{(DATA_W-IMM8_W){fd_instr[IMM8_W-1]}}, fd_instr[IMM8_W-1:0]};
   assign imm11 = {{(DATA_W-IMM11_W){fd_instr[IMM11_W-1]}}, fd_instr[IMM11_W-1:0]};

   // Write-through so a result written this cycle is seen here
   assign rs_val = (wb_en && wb_reg == rs) ? wb_data : rf[rs];
   assign rt_val = (wb_en && wb_reg == rt) ? wb_data : rf[rt];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            rf[i] <= '0;
         end
      end else if (wb_en) begin
         rf[wb_reg] <= wb_data;
      end
   end

   always_comb begin
      alu_op  = ALU_ADD;
      uses_rs = 1'b0;
      uses_rt = 1'b0;
      rt_to_b = 1'b0;
      wen     = 1'b0;
      illegal = 1'b0;
      dst     = rt;
      imm     = imm5;
      case (op)
         OP_HALT, OP_NOP: ;
         OP_J: imm = imm11;
         OP_ADDI, OP_LD: begin
            uses_rs = 1'b1;
            wen     = 1'b1;
         end
         OP_ST: begin
            uses_rs = 1'b1;
            uses_rt = 1'b1;
         end
         OP_BEQZ, OP_BNEZ: begin
            uses_rs = 1'b1;
            imm     = imm8;
         end
         OP_RTYPE: begin
            uses_rs = 1'b1;
            uses_rt = 1'b1;
            rt_to_b = 1'b1;
            wen     = 1'b1;
            dst     = rd;
            case (fn)
               FN_ADD: alu_op = ALU_ADD;
               FN_SUB: alu_op = ALU_SUB;
               FN_XOR: alu_op = ALU_XOR;
               FN_AND: alu_op = ALU_AND;
            endcase
         end
         default: illegal = 1'b1;
      endcase
   end

   // RAW against execute and memory; writeback is covered by write-through
   assign hz_e  = de_valid & de_wen & ((uses_rs & (de_dst == rs)) | (uses_rt & (de_dst == rt)));
   assign hz_m  = m_wen & ((uses_rs & (m_dst == rs)) | (uses_rt & (m_dst == rt)));
   assign stall = fd_valid & (hz_e | hz_m);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         de_valid <= 1'b0;
         m_wen    <= 1'b0;
      end else begin
         de_valid <= run & fd_valid & ~stall & ~flush;
         m_wen    <= run & de_valid & de_wen;
      end
   end

   always_ff @(posedge clk) begin
      m_dst         <= de_dst;
      de_op         <= op;
      de_alu_op     <= alu_op;
      de_a          <= rs_val;
      de_b          <= rt_to_b ? rt_val : imm;
      de_store_data <= rt_val;
      de_imm        <= imm;
      de_pc         <= fd_pc;
      de_dst        <= dst;
      de_wen        <= wen;
      de_illegal    <= illegal;
   end

endmodule

// File: design/execute.sv
`timescale 1ns/1ps
module execute
   import proc_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              de_valid,
   input  opcode_t           de_op,
   input  alu_op_t           de_alu_op,
   input  logic [DATA_W-1:0] de_a,
   input  logic [DATA_W-1:0] de_b,
   input  logic [DATA_W-1:0] de_store_data,
   input  logic [DATA_W-1:0] de_imm,
   input  logic [DATA_W-1:0] de_pc,
   input  logic [REG_AW-1:0] de_dst,
   input  logic              de_wen,
   input  logic              de_illegal,
   output logic              redirect,
   output logic [DATA_W-1:0] redirect_pc,
   output logic              flush,
   output logic              em_valid,
   output opcode_t           em_op,
   output logic [DATA_W-1:0] em_result,
   output logic [DATA_W-1:0] em_store_data,
   output logic [REG_AW-1:0] em_dst,
   output logic              em_wen,
   output logic              em_illegal
);

   logic [DATA_W-1:0] alu_y;
   logic [DATA_W-1:0] pc_plus2;
   logic              a_zero;
   logic              taken;

   // Also forms the LD/ST address from Rs plus imm5
   always_comb begin
      case (de_alu_op)
         ALU_ADD: alu_y = de_a + de_b;
         ALU_SUB: alu_y = de_a - de_b;
         ALU_XOR: alu_y = de_a ^ de_b;
         ALU_AND: alu_y = de_a & de_b;
      endcase
   end

   assign a_zero = (de_a == '0);

   always_comb begin
      taken = 1'b0;
      if (de_valid) begin
         case (de_op)
            OP_BEQZ: taken = a_zero;
            OP_BNEZ: taken = ~a_zero;
            OP_J:    taken = 1'b1;
            default: taken = 1'b0;
         endcase
      end
   end

   // Target is PC+2 plus the immediate in halfwords
   assign pc_plus2    = de_pc + DATA_W'(2);
   assign redirect_pc = pc_plus2 + {de_imm[DATA_W-2:0], 1'b0};
   assign redirect    = taken;
   // Kills the instruction now in decode
   assign flush       = taken;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         em_valid <= 1'b0;
      end else begin
         em_valid <= de_valid;
      end
   end

   always_ff @(posedge clk) begin
      em_op         <= de_op;
      em_result     <= alu_y;
      em_store_data <= de_store_data;
      em_dst        <= de_dst;
      em_wen        <= de_wen;
      em_illegal    <= de_illegal;
   end

endmodule

// File: design/fetch.sv
`timescale 1ns/1ps
module fetch
   import proc_pkg::*;
#(
   parameter int IMEM_DEPTH = 256
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              run,
   input  logic              stall,
   input  logic              redirect,
   input  logic [DATA_W-1:0] redirect_pc,
   input  logic              host_imem_we,
   input  logic [15:0]       host_addr,
   input  logic [DATA_W-1:0] host_wdata,
   output logic [DATA_W-1:0] host_imem_rdata,
   output logic              fd_valid,
   output logic [DATA_W-1:0] fd_instr,
   output logic [DATA_W-1:0] fd_pc
);

   localparam int IAW = $clog2(IMEM_DEPTH);

   logic [DATA_W-1:0] imem [IMEM_DEPTH];
   logic [DATA_W-1:0] pc;
   logic [DATA_W-1:0] instr;
   logic              advance;

   // Word-addressed instruction memory, PC bit 0 dropped
   assign instr           = imem[pc[IAW:1]];
   assign host_imem_rdata = imem[host_addr[IAW-1:0]];

   assign advance = run & ~redirect & ~stall;

   always_ff @(posedge clk) begin
      if (host_imem_we) begin
         imem[host_addr[IAW-1:0]] <= host_wdata;
      end
   end

   // Idle keeps the PC at zero so a start fetches from address 0
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc       <= '0;
         fd_valid <= 1'b0;
      end else if (!run) begin
         pc       <= '0;
         fd_valid <= 1'b0;
      end else if (redirect) begin
         // Drop the instruction fetched behind the taken branch
         pc       <= redirect_pc;
         fd_valid <= 1'b0;
      end else if (!stall) begin
         pc       <= pc + DATA_W'(2);
         fd_valid <= 1'b1;
      end
   end

   // Held while decode stalls
   always_ff @(posedge clk) begin
      if (advance) begin
         fd_instr <= instr;
         fd_pc    <= pc;
      end
   end

endmodule

// File: design/memory.sv
`timescale 1ns/1ps
module memory
   import proc_pkg::*;
#(
   parameter int DMEM_DEPTH = 256
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              run,
   input  logic              em_valid,
   input  opcode_t           em_op,
   input  logic [DATA_W-1:0] em_result,
   input  logic [DATA_W-1:0] em_store_data,
   input  logic [REG_AW-1:0] em_dst,
   input  logic              em_wen,
   input  logic              em_illegal,
   input  logic              host_dmem_we,
   input  logic [15:0]       host_addr,
   input  logic [DATA_W-1:0] host_wdata,
   output logic [DATA_W-1:0] host_dmem_rdata,
   output logic              halt_seen,
   output logic              illegal_seen,
   output logic              wb_en,
   output logic [REG_AW-1:0] wb_reg,
   output logic [DATA_W-1:0] wb_data
);

   localparam int DAW = $clog2(DMEM_DEPTH);

   logic [DATA_W-1:0] dmem [DMEM_DEPTH];
   logic [DAW-1:0]    d_idx;
   logic [DATA_W-1:0] sel_data;
   logic              live;
   logic              mw_valid;
   logic              mw_wen;

   // Once run drops nothing in flight may touch memory or status
   assign live  = run & em_valid;
   assign d_idx = em_result[DAW:1];

   assign halt_seen       = live & (em_op == OP_HALT);
   assign illegal_seen    = live & em_illegal;
   assign host_dmem_rdata = dmem[host_addr[DAW-1:0]];
   assign sel_data        = (em_op == OP_LD) ? dmem[d_idx] : em_result;

   always_ff @(posedge clk) begin
      if (live && em_op == OP_ST) begin
         dmem[d_idx] <= em_store_data;
      end else if (host_dmem_we) begin
         dmem[host_addr[DAW-1:0]] <= host_wdata;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mw_valid <= 1'b0;
      end else begin
         mw_valid <= live;
      end
   end

   always_ff @(posedge clk) begin
      mw_wen  <= em_wen;
      wb_reg  <= em_dst;
      wb_data <= sel_data;
   end

   assign wb_en = mw_valid & mw_wen;

endmodule

// File: design/proc.sv
`timescale 1ns/1ps
module proc
   import proc_pkg::*;
#(
   parameter int IMEM_DEPTH = 256,
   parameter int DMEM_DEPTH = 256
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [15:0]       paddr,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [DATA_W-1:0] pwdata,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   output logic              pslverr
);

   // Host side
   logic              run, halt_seen, illegal_seen;
   logic              host_imem_we, host_dmem_we;
   logic [15:0]       host_addr;
   logic [DATA_W-1:0] host_wdata, host_imem_rdata, host_dmem_rdata;
   // Pipeline
   logic              stall, redirect, flush;
   logic [DATA_W-1:0] redirect_pc;
   logic              fd_valid;
   logic [DATA_W-1:0] fd_instr, fd_pc;
   logic              de_valid, de_wen, de_illegal;
   opcode_t           de_op, em_op;
   alu_op_t           de_alu_op;
   logic [DATA_W-1:0] de_a, de_b, de_store_data, de_imm, de_pc;
   logic [REG_AW-1:0] de_dst, em_dst, wb_reg;
   logic              em_valid, em_wen, em_illegal, wb_en;
   logic [DATA_W-1:0] em_result, em_store_data, wb_data;

   apb_host_port #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) apb_i (.*);

   fetch #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_i (.*);

   decode decode_i (.*);

   execute execute_i (.*);

   memory #(.DMEM_DEPTH(DMEM_DEPTH)) memory_i (.*);

endmodule

// File: design/proc_pkg.sv
package proc_pkg;

   // Datapath and register file sizes
   localparam int DATA_W   = 16;
   localparam int REG_AW   = 3;
   localparam int NUM_REGS = 8;

   // Instruction field positions
   localparam int OP_HI = 15;
   localparam int OP_LO = 11;
   localparam int RS_HI = 10;
   localparam int RS_LO = 8;
   localparam int RT_HI = 7;
   localparam int RT_LO = 5;
   localparam int RD_HI = 4;
   localparam int RD_LO = 2;
   localparam int FN_HI = 1;
   localparam int FN_LO = 0;

   // Immediate widths, all taken from bit 0 upward and sign extended
   localparam int IMM5_W  = 5;
   localparam int IMM8_W  = 8;
   localparam int IMM11_W = 11;

   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_J     = 5'b00100,
      OP_ADDI  = 5'b01000,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_RTYPE = 5'b11011
   } opcode_t;

   typedef enum logic [1:0] {
      FN_ADD = 2'b00,
      FN_SUB = 2'b01,
      FN_XOR = 2'b10,
      FN_AND = 2'b11
   } funct_t;

   typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_AND} alu_op_t;

   // APB word addresses
   localparam logic [15:0] IMEM_BASE = 16'h0000;
   localparam logic [15:0] DMEM_BASE = 16'h1000;
   localparam logic [15:0] CTRL_ADDR = 16'h2000;
   localparam logic [15:0] STAT_ADDR = 16'h2001;

   localparam int CTRL_RUN_BIT  = 0;
   localparam int STAT_HALT_BIT = 0;
   localparam int STAT_ERR_BIT  = 1;

   // Each stage register carries a valid bit; payload is don't-care when it is low.
   // PC and LD/ST addresses are byte addresses, bit 0 is ignored by the memories
endpackage

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module proc_tb \
   -f sim.f -o proc_sim

out=$(./obj_dir/proc_sim 2>&1) || true
echo "$out"

if grep -q "TB PASSED" <<< "$out"; then
   exit 0
fi
exit 1

// File: sim.f
design/proc_pkg.sv
design/apb_host_port.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/proc.sv
tb/proc_props.sv
tb/proc_tb.sv

// File: tb/proc_props.sv
`timescale 1ns/1ps
module proc_props (
   input logic clk,
   input logic arst_n,
   input logic psel,
   input logic penable,
   input logic pready,
   input logic pslverr,
   input logic run,
   input logic halt_seen,
   input logic illegal_seen,
   input logic host_imem_we,
   input logic host_dmem_we
);

   // Zero wait states on every transfer
   pready_high: assert property (@(posedge clk) disable iff (!arst_n) pready)
      else $error("pready went low");

   slverr_in_access: assert property (@(posedge clk) disable iff (!arst_n)
      pslverr |-> (psel && penable))
      else $error("pslverr raised outside an access phase");

   // A run ends only through HALT or an illegal opcode
   run_fall_cause: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(run) |-> $past(halt_seen || illegal_seen))
      else $error("run fell without halt_seen or illegal_seen");

   no_host_write_in_run: assert property (@(posedge clk) disable iff (!arst_n)
      !(run && (host_imem_we || host_dmem_we)))
      else $error("host memory write enabled while running");

endmodule

bind proc proc_props props_i (
   .clk          (clk),
   .arst_n       (arst_n),
   .psel         (psel),
   .penable      (penable),
   .pready       (pready),
   .pslverr      (pslverr),
   .run          (run),
   .halt_seen    (halt_seen),
   .illegal_seen (illegal_seen),
   .host_imem_we (host_imem_we),
   .host_dmem_we (host_dmem_we)
);

// File: tb/proc_tb.sv
`timescale 1ns/1ps
module proc_tb
   import proc_pkg::*;
;

   // Five programs under 300 cycles each, plus about 3 cycles per host access
   localparam int TIMEOUT_CYCLES = 20000;

   logic        clk;
   logic        arst_n;
   logic [15:0] paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [15:0] pwdata;
   logic [15:0] prdata;
   logic        pready;
   logic        pslverr;

   int          errors;
   int          cycles;
   bit          finished;
   logic [31:0] lfsr_state;
   logic [15:0] prog [$];
   logic [15:0] exp_dmem [16];

   proc #(.IMEM_DEPTH(256), .DMEM_DEPTH(256)) dut_i (.*);

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Checks stopped with %0d errors", errors);
         $display("TB FAILED");
         finished = 1'b1;
         $finish;
      end
   end

   final begin
      if (!finished) begin
         $display("TB FAILED");
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [15:0] next_bits(input int n);
      logic [15:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v = {v[14:0], fb};
      end
      return v;
   endfunction

   function automatic logic [15:0] sext5(input logic [15:0] x);
      return {{11{x[4]}}, x[4:0]};
   endfunction

   // Byte-swapped address under a mask keeps every word distinct
   function automatic logic [15:0] fill_word(input logic [15:0] addr);
      return {addr[7:0], addr[15:8]} ^ 16'ha5c3;
   endfunction

   // Instruction assembly
   function automatic logic [15:0] enc_i(input opcode_t op, input logic [2:0] rs,
                                         input logic [2:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm[4:0]};
   endfunction

   function automatic logic [15:0] enc_r(input funct_t fn, input logic [2:0] rs,
                                         input logic [2:0] rt, input logic [2:0] rd);
      return {OP_RTYPE, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] enc_b(input opcode_t op, input logic [2:0] rs,
                                         input logic [15:0] imm);
      return {op, rs, imm[7:0]};
   endfunction

   function automatic logic [15:0] enc_j(input logic [15:0] imm);
      return {OP_J, imm[10:0]};
   endfunction

   function automatic logic [15:0] enc_halt();
      return {OP_HALT, 11'b0};
   endfunction

   // One APB transfer sampled late in the access phase
   task automatic apb_access(input logic [15:0] addr, input logic wr, input logic [15:0] wdata,
                             output logic [15:0] rdata, output logic err);
      @(posedge clk);
      #1;
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1;
      penable = 1'b1;
      #5;
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_err(input logic got, input logic exp);
      assert (got === exp) else begin
         errors++;
         $display("Error pslverr: got %h, expected %h", got, exp);
      end
   endtask

   task automatic apb_write(input logic [15:0] addr, input logic [15:0] data,
                            input logic exp_err);
      logic [15:0] rd;
      logic        err;
      apb_access(addr, 1'b1, data, rd, err);
      check_err(err, exp_err);
   endtask

   task automatic apb_read(input logic [15:0] addr, input logic [15:0] exp,
                           input logic exp_err);
      logic [15:0] rd;
      logic        err;
      apb_access(addr, 1'b0, 16'h0, rd, err);
      check_err(err, exp_err);
      if (!exp_err) begin
         assert (rd === exp) else begin
            errors++;
            $display("Error prdata at %h: got %h, expected %h", addr, rd, exp);
         end
      end
   endtask

   // Program goes to IMEM from 0 with HALT padding behind it
   task automatic load_program();
      for (int i = 0; i < prog.size(); i++) begin
         apb_write(IMEM_BASE + 16'(i), prog[i], 1'b0);
      end
      for (int i = 0; i < 4; i++) begin
         apb_write(IMEM_BASE + 16'(prog.size() + i), enc_halt(), 1'b0);
      end
      // Low DMEM gets a pattern unique to each address
      for (int w = 0; w < 16; w++) begin
         exp_dmem[w] = fill_word(DMEM_BASE + 16'(w));
         apb_write(DMEM_BASE + 16'(w), exp_dmem[w], 1'b0);
      end
   endtask

   task automatic wait_halted();
      logic [15:0] rd;
      logic        err;
      do begin
         apb_access(STAT_ADDR, 1'b0, 16'h0, rd, err);
         check_err(err, 1'b0);
      end while (!rd[STAT_HALT_BIT]);
   endtask

   task automatic run_program();
      apb_write(CTRL_ADDR, 16'h1, 1'b0);
      wait_halted();
   endtask

   task automatic check_dmem();
      for (int w = 0; w < 16; w++) begin
         apb_read(DMEM_BASE + 16'(w), exp_dmem[w], 1'b0);
      end
   endtask

   task automatic test_host_access();
      logic [15:0] iw [8];
      logic [15:0] dw [8];
      for (int i = 0; i < 8; i++) begin
         iw[i] = next_bits(16);
         dw[i] = next_bits(16);
         apb_write(IMEM_BASE + 16'h40 + 16'(i), iw[i], 1'b0);
         apb_write(DMEM_BASE + 16'h40 + 16'(i), dw[i], 1'b0);
      end
      for (int i = 0; i < 8; i++) begin
         apb_read(IMEM_BASE + 16'h40 + 16'(i), iw[i], 1'b0);
         apb_read(DMEM_BASE + 16'h40 + 16'(i), dw[i], 1'b0);
      end
      // Countdown loop keeps the core busy while the host is refused
      prog = {};
      prog.push_back(enc_i(OP_ADDI, 3'd0, 3'd1, 16'd15));
      prog.push_back(enc_i(OP_ADDI, 3'd1, 3'd1, 16'(-1)));
      prog.push_back(enc_b(OP_BNEZ, 3'd1, 16'(-2)));
      prog.push_back(enc_halt());
      load_program();
      apb_write(CTRL_ADDR, 16'h1, 1'b0);
      apb_read(CTRL_ADDR, 16'h1, 1'b0);
      apb_read(IMEM_BASE + 16'h40, iw[0], 1'b1);
      apb_write(IMEM_BASE + 16'h40, ~iw[0], 1'b1);
      apb_write(DMEM_BASE + 16'h40, ~dw[0], 1'b1);
      apb_read(DMEM_BASE + 16'h40, dw[0], 1'b1);
      wait_halted();
      apb_read(CTRL_ADDR, 16'h0, 1'b0);
      apb_read(IMEM_BASE + 16'h40, iw[0], 1'b0);
      apb_read(DMEM_BASE + 16'h40, dw[0], 1'b0);
      apb_read(STAT_ADDR, 16'h1, 1'b0);
      apb_read(16'h3000, 16'h0, 1'b1);
      apb_write(STAT_ADDR, 16'h0, 1'b1);
   endtask

   task automatic test_arith();
      logic [15:0] a, b, imm;
      a   = next_bits(16);
      b   = next_bits(16);
      imm = sext5(next_bits(5));
      prog = {};
      prog.push_back(enc_i(OP_LD, 3'd0, 3'd1, 16'd0));
      prog.push_back(enc_i(OP_LD, 3'd0, 3'd2, 16'd2));
      prog.push_back(enc_r(FN_ADD, 3'd1, 3'd2, 3'd3));
      prog.push_back(enc_r(FN_SUB, 3'd1, 3'd2, 3'd4));
      prog.push_back(enc_r(FN_XOR, 3'd1, 3'd2, 3'd5));
      prog.push_back(enc_r(FN_AND, 3'd1, 3'd2, 3'd6));
      prog.push_back(enc_i(OP_ADDI, 3'd1, 3'd7, imm));
      for (int r = 3; r <= 7; r++) begin
         prog.push_back(enc_i(OP_ST, 3'd0, 3'(r), 16'(2 * (r - 1))));
      end
      prog.push_back(enc_halt());
      load_program();
      apb_write(DMEM_BASE, a, 1'b0);
      apb_write(DMEM_BASE + 16'd1, b, 1'b0);
      exp_dmem[0] = a;
      exp_dmem[1] = b;
      exp_dmem[2] = a + b;
      exp_dmem[3] = a - b;
      exp_dmem[4] = a ^ b;
      exp_dmem[5] = a & b;
      exp_dmem[6] = a + imm;
      run_program();
      check_dmem();
      apb_read(STAT_ADDR, 16'h1, 1'b0);
   endtask

   task automatic test_hazards();
      logic [15:0] i1, i2, i3, r1, r2, r3, r4, r5, r6;
      i1 = sext5(next_bits(5));
      i2 = sext5(next_bits(5));
      i3 = sext5(next_bits(5));
      r1 = i1;
      r2 = r1 + i2;
      r3 = r2 ^ r1;
      r4 = r3 - r2;
      r5 = r4 & r3;
      r6 = r5 + i3;
      prog = {};
      prog.push_back(enc_i(OP_ADDI, 3'd0, 3'd1, i1));
      prog.push_back(enc_i(OP_ADDI, 3'd1, 3'd2, i2));
      prog.push_back(enc_r(FN_XOR, 3'd2, 3'd1, 3'd3));
      prog.push_back(enc_r(FN_SUB, 3'd3, 3'd2, 3'd4));
      prog.push_back(enc_r(FN_AND, 3'd4, 3'd3, 3'd5));
      prog.push_back(enc_i(OP_ADDI, 3'd5, 3'd6, i3));
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd6, 16'd0));
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd4, 16'd2));
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd2, 16'd4));
      prog.push_back(enc_halt());
      load_program();
      exp_dmem[0] = r6;
      exp_dmem[1] = r4;
      exp_dmem[2] = r2;
      run_program();
      check_dmem();
   endtask

   task automatic test_control();
      logic [15:0] d0;
      // Bit 15 clear and bit 0 set keep d0 + 1 nonzero
      d0 = {1'b0, next_bits(15)} | 16'h1;
      prog = {};
      prog.push_back(enc_i(OP_LD, 3'd0, 3'd1, 16'd0));
      prog.push_back(enc_i(OP_ADDI, 3'd1, 3'd1, 16'd1));
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd1, 16'd2));
      prog.push_back(enc_b(OP_BEQZ, 3'd0, 16'd2));
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd1, 16'd4));
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd1, 16'd6));
      prog.push_back(enc_b(OP_BEQZ, 3'd1, 16'd2));
      prog.push_back(enc_i(OP_ADDI, 3'd0, 3'd2, 16'd5));
      prog.push_back(enc_b(OP_BNEZ, 3'd2, 16'd2));
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd1, 16'd8));
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd1, 16'd10));
      prog.push_back(enc_j(16'd2));
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd1, 16'd12));
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd1, 16'd14));
      // With r2 at 5 this is byte 16 or word 8
      prog.push_back(enc_i(OP_ST, 3'd2, 3'd1, 16'd11));
      prog.push_back(enc_halt());
      load_program();
      apb_write(DMEM_BASE, d0, 1'b0);
      exp_dmem[0] = d0;
      exp_dmem[1] = d0 + 16'd1;
      exp_dmem[8] = d0 + 16'd1;
      run_program();
      check_dmem();
   endtask

   task automatic test_illegal();
      prog = {};
      prog.push_back(enc_i(OP_ADDI, 3'd0, 3'd1, 16'd3));
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd1, 16'd0));
      prog.push_back({5'b11111, 11'b0});
      prog.push_back(enc_i(OP_ST, 3'd0, 3'd1, 16'd2));
      prog.push_back(enc_halt());
      load_program();
      exp_dmem[0] = 16'd3;
      run_program();
      check_dmem();
      apb_read(STAT_ADDR, 16'h3, 1'b0);
      // Restart clears halted and err until the opcode comes round again
      apb_write(CTRL_ADDR, 16'h1, 1'b0);
      apb_read(STAT_ADDR, 16'h0, 1'b0);
      wait_halted();
      apb_read(STAT_ADDR, 16'h3, 1'b0);
   endtask

   initial begin
      clk        = 1'b0;
      arst_n     = 1'b0;
      paddr      = '0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      pwdata     = '0;
      errors     = 0;
      cycles     = 0;
      finished   = 1'b0;
      lfsr_state = 32'haee0;
      repeat (16) @(posedge clk);
      #1;
      arst_n = 1'b1;
      test_host_access();
      test_arith();
      test_hazards();
      test_control();
      test_illegal();
      $display("Checks complete with %0d errors", errors);
      finished = 1'b1;
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule
